// File: field_addsub.sv
`timescale 1ns/100ps
`default_nettype none

module field_addsub #(
	parameter int FIELD_BITS = ladder_pkg::DEFAULT_FIELD_BITS,
	parameter logic [FIELD_BITS-1:0] FIELD_PRIME = ladder_pkg::DEFAULT_FIELD_PRIME
) (
	input wire                   clk,
	input wire                   reset,
	input wire                   en,
	input wire [FIELD_BITS-1:0]  a,
	input wire [FIELD_BITS-1:0]  b,
	output logic                 valid,
	output logic [FIELD_BITS-1:0] sum,
	output logic [FIELD_BITS-1:0] diff
);

	localparam logic [FIELD_BITS:0] PRIME_EXT = {1'b0, FIELD_PRIME};

	logic [FIELD_BITS:0] sum_raw;	// One spare bit for carry
	logic [FIELD_BITS:0] diff_raw;	// Top bit is the borrow

	always_comb begin
		sum_raw = {1'b0, a} + {1'b0, b};
		if (sum_raw >= PRIME_EXT)
			sum_raw = sum_raw - PRIME_EXT;	// Single correction, inputs reduced

		diff_raw = {1'b0, a} - {1'b0, b};
		if (diff_raw[FIELD_BITS])
			diff_raw = diff_raw + PRIME_EXT;	// Wrapped below zero
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else
			valid <= en;	// One cycle latency

		if (en) begin
			sum  <= sum_raw[FIELD_BITS-1:0];
			diff <= diff_raw[FIELD_BITS-1:0];
		end
	end

endmodule

`default_nettype wire

// File: field_mult.sv
`timescale 1ns/100ps
`default_nettype none

module field_mult #(
	parameter int FIELD_BITS = ladder_pkg::DEFAULT_FIELD_BITS,
	parameter logic [FIELD_BITS-1:0] FIELD_PRIME = ladder_pkg::DEFAULT_FIELD_PRIME
) (
	input wire                    clk,
	input wire                    reset,
	input wire                    en,
	input wire [FIELD_BITS-1:0]   a,
	input wire [FIELD_BITS-1:0]   b,
	output logic                  valid,
	output logic [FIELD_BITS-1:0] product	// Doubles as the accumulator
);

	localparam int CNT_BITS = $clog2(FIELD_BITS + 1);
	localparam logic [FIELD_BITS:0] PRIME_EXT = {1'b0, FIELD_PRIME};

	logic [FIELD_BITS-1:0] a_r;
	logic [FIELD_BITS-1:0] b_r;		// Shifts left, top bit consumed
	logic [CNT_BITS-1:0]   count;	// Iterations left
	logic                  running;

	logic [FIELD_BITS:0]   dbl;
	logic [FIELD_BITS:0]   dbl_add;
	logic [FIELD_BITS-1:0] acc_next;

	////////////////////
	// One shift-and-add iteration

	always_comb begin
		dbl = {product, 1'b0};			// 2 * acc
		if (dbl >= PRIME_EXT)
			dbl = dbl - PRIME_EXT;

		dbl_add = dbl + {1'b0, a_r};	// Both terms below the prime
		if (dbl_add >= PRIME_EXT)
			dbl_add = dbl_add - PRIME_EXT;

		acc_next = b_r[FIELD_BITS-1] ? dbl_add[FIELD_BITS-1:0] : dbl[FIELD_BITS-1:0];
	end

	////////////////////
	// Sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			valid   <= 1'b0;
			count   <= '0;
		end else begin
			valid <= 1'b0;
			if (en) begin
				running <= 1'b1;
				count   <= CNT_BITS'(FIELD_BITS);
			end else if (running) begin
				count <= count - 1'b1;
				if (count == CNT_BITS'(1)) begin	// Last bit of b
					running <= 1'b0;
					valid   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			a_r     <= a;
			b_r     <= b;
			product <= '0;
		end else if (running) begin
			product <= acc_next;
			b_r     <= {b_r[FIELD_BITS-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: ladder_microcode.sv
`timescale 1ns/100ps
`default_nettype none

module ladder_microcode (
	input wire ladder_pkg::step_state_t state,
	output ladder_pkg::ucode_line_t     line
);

	// Field order: enables {swap, addsub, mult}, addsub a/b, mult a/b,
	// sum/diff/product targets, advance source, next state
	always_comb begin
		case (state)
			ladder_pkg::SWAPPED: line = {3'b010,	// a0 into TEMP_0, a0h into TEMP_1
				ladder_pkg::SWAP_P_X, ladder_pkg::SWAP_P_Z, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::TEMP_0, ladder_pkg::TEMP_1, ladder_pkg::NONE,
				ladder_pkg::ADV_ADDSUB, ladder_pkg::A0};
			ladder_pkg::A0: line = {3'b011,			// a1 and a1h, b0 = a0 squared
				ladder_pkg::SWAP_Q_X, ladder_pkg::SWAP_Q_Z, ladder_pkg::TEMP_0, ladder_pkg::TEMP_0,
				ladder_pkg::TEMP_2, ladder_pkg::TEMP_3, ladder_pkg::TEMP_4,
				ladder_pkg::ADV_MULT, ladder_pkg::B0_LO};
			ladder_pkg::B0_LO: line = {3'b001,		// b0h into TEMP_5
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_1, ladder_pkg::TEMP_1,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_5,
				ladder_pkg::ADV_MULT, ladder_pkg::B0_HI};
			ladder_pkg::B0_HI: line = {3'b001,		// Last read of a0h, TEMP_1 becomes b1
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_2, ladder_pkg::TEMP_1,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_1,
				ladder_pkg::ADV_MULT, ladder_pkg::B1_LO};
			ladder_pkg::B1_LO: line = {3'b001,		// b1h overwrites a0
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_3, ladder_pkg::TEMP_0,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_0,
				ladder_pkg::ADV_MULT, ladder_pkg::B1_HI};
			ladder_pkg::B1_HI: line = {3'b010,		// c1 in TEMP_0, c1h in TEMP_1
				ladder_pkg::TEMP_1, ladder_pkg::TEMP_0, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::TEMP_0, ladder_pkg::TEMP_1, ladder_pkg::NONE,
				ladder_pkg::ADV_ADDSUB, ladder_pkg::C1};
			ladder_pkg::C1: line = {3'b011,			// s into TEMP_1, r into TEMP_2
				ladder_pkg::TEMP_4, ladder_pkg::TEMP_5, ladder_pkg::TEMP_1, ladder_pkg::TEMP_1,
				ladder_pkg::NONE, ladder_pkg::TEMP_1, ladder_pkg::TEMP_2,
				ladder_pkg::ADV_MULT, ladder_pkg::R};
			ladder_pkg::R: line = {3'b001,			// t = s * A24
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_1, ladder_pkg::CONST_A24,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_3,
				ladder_pkg::ADV_MULT, ladder_pkg::T};
			ladder_pkg::T: line = {3'b011,			// u into TEMP_4, nx into TEMP_3
				ladder_pkg::TEMP_3, ladder_pkg::TEMP_4, ladder_pkg::TEMP_4, ladder_pkg::TEMP_5,
				ladder_pkg::TEMP_4, ladder_pkg::NONE, ladder_pkg::TEMP_3,
				ladder_pkg::ADV_MULT, ladder_pkg::XB_LO};
			ladder_pkg::XB_LO: line = {3'b001,		// nz = s * u
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_1, ladder_pkg::TEMP_4,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_1,
				ladder_pkg::ADV_MULT, ladder_pkg::XB_HI};
			ladder_pkg::XB_HI: line = {3'b001,		// mx = c1 squared
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_0, ladder_pkg::TEMP_0,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_0,
				ladder_pkg::ADV_MULT, ladder_pkg::XN_LO};
			ladder_pkg::XN_LO: line = {3'b001,		// mz = r * base u
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_2, ladder_pkg::BASE_U,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::TEMP_2,
				ladder_pkg::ADV_MULT, ladder_pkg::XN_HI};
			ladder_pkg::XN_HI: line = {3'b100,		// Swap back, operands wired in the step
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::ADV_SWAP, ladder_pkg::IDLE};
			default: line = {3'b000,				// Idle, wait for the entry swap
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::NONE, ladder_pkg::NONE, ladder_pkg::NONE,
				ladder_pkg::ADV_SWAP, ladder_pkg::SWAPPED};
		endcase
	end

endmodule

`default_nettype wire

// File: ladder_pkg.sv
`default_nettype none

package ladder_pkg;

	////////////////////
	// Field and scalar defaults

	localparam int DEFAULT_FIELD_BITS = 16;
	localparam logic [15:0] DEFAULT_FIELD_PRIME = 16'd65521;	// Largest 16 bit prime
	localparam logic [15:0] DEFAULT_A24 = 16'd56144;			// 121665 mod 65521
	localparam int DEFAULT_SCALAR_BITS = 16;

	// Operand and destination ids
	typedef enum logic [3:0] {
		TEMP_0    = 4'h0,	// General purpose temporaries
		TEMP_1    = 4'h1,
		TEMP_2    = 4'h2,
		TEMP_3    = 4'h3,
		TEMP_4    = 4'h4,
		TEMP_5    = 4'h5,
		SWAP_P_X  = 4'h6,	// Swap unit outputs, read only
		SWAP_P_Z  = 4'h7,
		SWAP_Q_X  = 4'h8,
		SWAP_Q_Z  = 4'h9,
		CONST_A24 = 4'ha,	// Curve constant
		BASE_U    = 4'hb,	// Base point u
		NONE      = 4'hc		// Result dropped
	} reg_id_t;

	// One state per microcode line
	typedef enum logic [3:0] {
		IDLE    = 4'h0,
		SWAPPED = 4'h1,
		A0      = 4'h2,
		B0_LO   = 4'h3,
		B0_HI   = 4'h4,
		B1_LO   = 4'h5,
		B1_HI   = 4'h6,
		C1      = 4'h7,
		R       = 4'h8,
		T       = 4'h9,
		XB_LO   = 4'ha,
		XB_HI   = 4'hb,
		XN_LO   = 4'hc,
		XN_HI   = 4'hd
	} step_state_t;

	// Which unit valid moves the program on
	typedef enum logic [1:0] {
		ADV_ADDSUB = 2'd0,
		ADV_MULT   = 2'd1,
		ADV_SWAP   = 2'd2
	} advance_t;

	typedef struct packed {
		logic        swap_en;
		logic        addsub_en;
		logic        mult_en;
		reg_id_t     addsub_a;
		reg_id_t     addsub_b;
		reg_id_t     mult_a;
		reg_id_t     mult_b;
		reg_id_t     sum_out;
		reg_id_t     diff_out;
		reg_id_t     mult_out;
		advance_t    advance_on;
		step_state_t next;
	} ucode_line_t;

endpackage

`default_nettype wire

// File: ladder_step.sv
`timescale 1ns/100ps
`default_nettype none

module ladder_step #(
	parameter int FIELD_BITS = ladder_pkg::DEFAULT_FIELD_BITS,
	parameter logic [FIELD_BITS-1:0] FIELD_PRIME = ladder_pkg::DEFAULT_FIELD_PRIME,
	parameter logic [FIELD_BITS-1:0] A24 = ladder_pkg::DEFAULT_A24
) (
	input wire                    clk,
	input wire                    reset,
	input wire                    step_start,
	input wire                    bit_val,
	input wire                    seed,		// Use (1,0),(u,1) instead of in_*
	input wire [FIELD_BITS-1:0]   base_u,
	input wire [FIELD_BITS-1:0]   in_px,
	input wire [FIELD_BITS-1:0]   in_pz,
	input wire [FIELD_BITS-1:0]   in_qx,
	input wire [FIELD_BITS-1:0]   in_qz,
	output logic                  step_done,
	output logic [FIELD_BITS-1:0] out_px,
	output logic [FIELD_BITS-1:0] out_pz,
	output logic [FIELD_BITS-1:0] out_qx,
	output logic [FIELD_BITS-1:0] out_qz
);

	localparam logic [FIELD_BITS-1:0] ONE = FIELD_BITS'(1);

	ladder_pkg::step_state_t state;
	ladder_pkg::ucode_line_t line;
	logic                    advancing;
	logic                    advancing_ff;	// Issue one cycle after the move

	logic [FIELD_BITS-1:0] temps [0:5];
	logic [FIELD_BITS-1:0] src [0:15];		// Every readable operand by id

	////////////////////
	// Shared units

	logic                  addsub_en;
	logic [FIELD_BITS-1:0] addsub_a;
	logic [FIELD_BITS-1:0] addsub_b;
	logic                  addsub_valid;
	logic [FIELD_BITS-1:0] addsub_sum;
	logic [FIELD_BITS-1:0] addsub_diff;

	logic                  mult_en;
	logic [FIELD_BITS-1:0] mult_a;
	logic [FIELD_BITS-1:0] mult_b;
	logic                  mult_valid;
	logic [FIELD_BITS-1:0] mult_product;

	logic                  swap_en;
	logic                  swap_bit;		// Held for the whole step
	logic [FIELD_BITS-1:0] swap_r_x;
	logic [FIELD_BITS-1:0] swap_r_z;
	logic [FIELD_BITS-1:0] swap_s_x;
	logic [FIELD_BITS-1:0] swap_s_z;
	logic                  swap_valid;

	ladder_microcode ucode (.state(state), .line(line));

	field_addsub #(.FIELD_BITS(FIELD_BITS), .FIELD_PRIME(FIELD_PRIME)) addsub (
		.clk(clk), .reset(reset), .en(addsub_en), .a(addsub_a), .b(addsub_b),
		.valid(addsub_valid), .sum(addsub_sum), .diff(addsub_diff)
	);

	field_mult #(.FIELD_BITS(FIELD_BITS), .FIELD_PRIME(FIELD_PRIME)) mult (
		.clk(clk), .reset(reset), .en(mult_en), .a(mult_a), .b(mult_b),
		.valid(mult_valid), .product(mult_product)
	);

	// Entry and exit swap share one instance, outputs are the step result
	ladder_swap #(.FIELD_BITS(FIELD_BITS)) swap (
		.clk(clk), .reset(reset), .en(swap_en), .bit_val(swap_bit),
		.r_x(swap_r_x), .r_z(swap_r_z), .s_x(swap_s_x), .s_z(swap_s_z),
		.valid(swap_valid), .p_x(out_px), .p_z(out_pz), .q_x(out_qx), .q_z(out_qz)
	);

	////////////////////
	// Operand sources and advance

	always_comb begin
		for (int i = 0; i < 16; i++)
			src[i] = '0;				// Unused ids read zero
		for (int i = 0; i < 6; i++)
			src[i] = temps[i];
		src[ladder_pkg::SWAP_P_X]  = out_px;
		src[ladder_pkg::SWAP_P_Z]  = out_pz;
		src[ladder_pkg::SWAP_Q_X]  = out_qx;
		src[ladder_pkg::SWAP_Q_Z]  = out_qz;
		src[ladder_pkg::CONST_A24] = A24;
		src[ladder_pkg::BASE_U]    = base_u;

		advancing = (addsub_valid && line.advance_on == ladder_pkg::ADV_ADDSUB) ||
			(mult_valid && line.advance_on == ladder_pkg::ADV_MULT) ||
			(swap_valid && line.advance_on == ladder_pkg::ADV_SWAP);
	end

	assign step_done = swap_valid && (state == ladder_pkg::XN_HI);	// Exit swap landed

	////////////////////
	// State and enables

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= ladder_pkg::IDLE;
			advancing_ff <= 1'b0;
			addsub_en    <= 1'b0;
			mult_en      <= 1'b0;
			swap_en      <= 1'b0;
		end else begin
			addsub_en    <= 1'b0;
			mult_en      <= 1'b0;
			swap_en      <= 1'b0;
			advancing_ff <= advancing;
			if (advancing)
				state <= line.next;
			if (advancing_ff) begin		// Line of the new state
				addsub_en <= line.addsub_en;
				mult_en   <= line.mult_en;
				swap_en   <= line.swap_en;
			end
			if (step_start)
				swap_en <= 1'b1;		// Entry swap
		end
	end

	////////////////////
	// Write back and operand registers

	always_ff @(posedge clk) begin
		if (addsub_valid && line.sum_out <= ladder_pkg::TEMP_5)
			temps[line.sum_out[2:0]] <= addsub_sum;
		if (addsub_valid && line.diff_out <= ladder_pkg::TEMP_5)
			temps[line.diff_out[2:0]] <= addsub_diff;
		if (mult_valid && line.mult_out <= ladder_pkg::TEMP_5)
			temps[line.mult_out[2:0]] <= mult_product;

		if (advancing_ff) begin
			addsub_a <= src[line.addsub_a];
			addsub_b <= src[line.addsub_b];
			mult_a   <= src[line.mult_a];
			mult_b   <= src[line.mult_b];
			swap_r_x <= temps[3];		// nx
			swap_r_z <= temps[1];		// nz
			swap_s_x <= temps[0];		// mx
			swap_s_z <= temps[2];		// mz
		end

		if (step_start) begin
			swap_bit <= bit_val;
			swap_r_x <= seed ? ONE : in_px;
			swap_r_z <= seed ? '0 : in_pz;
			swap_s_x <= seed ? base_u : in_qx;
			swap_s_z <= seed ? ONE : in_qz;
		end
	end

endmodule

`default_nettype wire

// File: ladder_swap.sv
`timescale 1ns/100ps
`default_nettype none

module ladder_swap #(
	parameter int FIELD_BITS = ladder_pkg::DEFAULT_FIELD_BITS
) (
	input wire                    clk,
	input wire                    reset,
	input wire                    en,
	input wire                    bit_val,
	input wire [FIELD_BITS-1:0]   r_x,
	input wire [FIELD_BITS-1:0]   r_z,
	input wire [FIELD_BITS-1:0]   s_x,
	input wire [FIELD_BITS-1:0]   s_z,
	output logic                  valid,
	output logic [FIELD_BITS-1:0] p_x,
	output logic [FIELD_BITS-1:0] p_z,
	output logic [FIELD_BITS-1:0] q_x,
	output logic [FIELD_BITS-1:0] q_z
);

	always_ff @(posedge clk) begin
		if (reset)
			valid <= 1'b0;
		else
			valid <= en;

		// Outputs held between enables, step reads them as operands
		if (en) begin
			p_x <= bit_val ? s_x : r_x;
			p_z <= bit_val ? s_z : r_z;
			q_x <= bit_val ? r_x : s_x;
			q_z <= bit_val ? r_z : s_z;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the scalar ladder testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_scalar_ladder -f scalar_ladder.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	exit 0
fi
exit 1

// File: scalar_ladder.f
ladder_pkg.sv
field_addsub.sv
field_mult.sv
ladder_swap.sv
ladder_microcode.sv
ladder_step.sv
scalar_ladder.sv
tb_clock.sv
tb_scalar_ladder.sv

// File: scalar_ladder.sv
`timescale 1ns/100ps
`default_nettype none

module scalar_ladder #(
	parameter int FIELD_BITS = ladder_pkg::DEFAULT_FIELD_BITS,
	parameter logic [FIELD_BITS-1:0] FIELD_PRIME = ladder_pkg::DEFAULT_FIELD_PRIME,
	parameter logic [FIELD_BITS-1:0] A24 = ladder_pkg::DEFAULT_A24,
	parameter int SCALAR_BITS = ladder_pkg::DEFAULT_SCALAR_BITS
) (
	input wire                    clk,
	input wire                    reset,
	input wire                    start,
	input wire [FIELD_BITS-1:0]   base_u,
	input wire [SCALAR_BITS-1:0]  scalar,
	output logic                  busy,
	output logic                  done,
	output logic [FIELD_BITS-1:0] result_x,
	output logic [FIELD_BITS-1:0] result_z
);

	localparam int IDX_BITS = (SCALAR_BITS > 1) ? $clog2(SCALAR_BITS) : 1;

	logic [SCALAR_BITS-1:0] scalar_r;
	logic [FIELD_BITS-1:0]  base_r;
	logic [IDX_BITS-1:0]    bit_idx;	// Counts down from the top bit
	logic                   first;		// Seed the first step
	logic                   step_start;
	wire                    step_done;

	// Step outputs loop back as the next step inputs
	wire [FIELD_BITS-1:0] px;
	wire [FIELD_BITS-1:0] pz;
	wire [FIELD_BITS-1:0] qx;
	wire [FIELD_BITS-1:0] qz;

	ladder_step #(.FIELD_BITS(FIELD_BITS), .FIELD_PRIME(FIELD_PRIME), .A24(A24)) step (
		.clk(clk), .reset(reset), .step_start(step_start), .bit_val(scalar_r[bit_idx]),
		.seed(first), .base_u(base_r),
		.in_px(px), .in_pz(pz), .in_qx(qx), .in_qz(qz),
		.step_done(step_done),
		.out_px(px), .out_pz(pz), .out_qx(qx), .out_qz(qz)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			done       <= 1'b0;
			step_start <= 1'b0;
			first      <= 1'b0;
			bit_idx    <= '0;
			result_x   <= '0;
			result_z   <= '0;
		end else begin
			done       <= 1'b0;
			step_start <= 1'b0;
			if (start && !busy) begin	// Start while busy is dropped
				busy       <= 1'b1;
				step_start <= 1'b1;
				first      <= 1'b1;
				bit_idx    <= IDX_BITS'(SCALAR_BITS - 1);
			end else if (step_done) begin
				first <= 1'b0;
				if (bit_idx == '0) begin	// Bit 0 finished
					busy     <= 1'b0;
					done     <= 1'b1;
					result_x <= px;
					result_z <= pz;
				end else begin
					bit_idx    <= bit_idx - 1'b1;
					step_start <= 1'b1;
				end
			end
		end
	end

	// Operands captured with an accepted start
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			scalar_r <= scalar;
			base_r   <= base_u;
		end
	end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 5	// 10 ns period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tb_scalar_ladder.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scalar_ladder;

	localparam longint PRIME = 65521;
	localparam longint A24_VAL = 56144;		// 121665 mod 65521
	localparam int SCALAR_BITS = 16;
	localparam int RUN_COUNT = 20;			// 17 runs issued plus margin
	localparam int STEP_CYCLES = 250;		// Ten multiplies of 19 cycles plus swaps
	localparam int TIMEOUT = RUN_COUNT * SCALAR_BITS * STEP_CYCLES;

	wire         clk;
	logic        reset;
	logic        start;
	logic [15:0] base_u;
	logic [15:0] scalar;
	wire         busy;
	wire         done;
	wire  [15:0] result_x;
	wire  [15:0] result_z;

	int cycles = 0;
	int value_errors = 0;
	int proto_errors = 0;
	int checks = 0;
	int done_count = 0;
	int accepted = 0;
	int seed;
	logic first_start = 1'b0;		// No start driven yet

	logic [15:0] exp_x_q [$];		// Model results in start order
	logic [15:0] exp_z_q [$];
	logic [15:0] want_x;
	logic [15:0] want_z;
	logic [15:0] rand_k;
	logic [15:0] rand_u;

	tb_clock clock_gen (.clk(clk));

	scalar_ladder dut (
		.clk(clk), .reset(reset), .start(start), .base_u(base_u), .scalar(scalar),
		.busy(busy), .done(done), .result_x(result_x), .result_z(result_z)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, a run never finished", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////
	// Handshake properties

	assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			$display("done stayed high for more than one cycle at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (reset) done |-> !busy)
		else begin
			$display("busy still high during the done pulse at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> done)
		else begin
			$display("busy fell without a done pulse at %0t", $time);
			proto_errors++;
		end
	assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
		else begin
			$display("start while idle did not raise busy at %0t", $time);
			proto_errors++;
		end

	////////////////////
	// Mid-cycle monitor

	always @(negedge clk) begin
		if (cycles != 0 && !first_start) begin	// Reset and idle before first run
			assert (!busy && !done && result_x == 16'd0 && result_z == 16'd0)
				else begin
					$display("busy, done or results not cleared by reset at %0t", $time);
					proto_errors++;
				end
		end
		if (cycles != 0 && done) begin
			done_count++;
			assert (exp_x_q.size() > 0)
				else begin
					$display("done pulsed at %0t with no accepted start pending", $time);
					proto_errors++;
				end
			if (exp_x_q.size() > 0) begin
				want_x = exp_x_q.pop_front();
				want_z = exp_z_q.pop_front();
				checks++;
				assert (result_x == want_x)
					else begin
						$display("** Error at %0t: result_x expected 0x%04h, got 0x%04h",
							$time, want_x, result_x);
						value_errors++;
					end
				assert (result_z == want_z)
					else begin
						$display("** Error at %0t: result_z expected 0x%04h, got 0x%04h",
							$time, want_z, result_z);
						value_errors++;
					end
			end
		end
	end

	// Montgomery ladder in plain integers from the top bit
	task automatic ladder_model(input logic [15:0] k, input logic [15:0] u,
		output logic [15:0] rx, output logic [15:0] rz);
		longint x2;
		longint z2;
		longint x3;
		longint z3;
		longint tmp;
		longint a;
		longint b;
		longint aa;
		longint bb;
		longint e;
		longint c;
		longint d;
		longint da;
		longint cb;
		longint ul;
		x2 = 1;
		z2 = 0;
		ul = longint'(u);
		x3 = ul;
		z3 = 1;
		for (int i = SCALAR_BITS - 1; i >= 0; i--) begin
			if (k[i]) begin				// Swap in
				tmp = x2;
				x2 = x3;
				x3 = tmp;
				tmp = z2;
				z2 = z3;
				z3 = tmp;
			end
			a  = (x2 + z2) % PRIME;
			b  = (x2 - z2 + PRIME) % PRIME;
			aa = (a * a) % PRIME;
			bb = (b * b) % PRIME;
			e  = (aa - bb + PRIME) % PRIME;
			c  = (x3 + z3) % PRIME;
			d  = (x3 - z3 + PRIME) % PRIME;
			da = (d * a) % PRIME;
			cb = (c * b) % PRIME;
			x3 = (da + cb) % PRIME;
			x3 = (x3 * x3) % PRIME;		// Differential add
			z3 = (da - cb + PRIME) % PRIME;
			z3 = (((z3 * z3) % PRIME) * ul) % PRIME;
			x2 = (aa * bb) % PRIME;		// Doubling
			z2 = (e * ((aa + (A24_VAL * e) % PRIME) % PRIME)) % PRIME;
			if (k[i]) begin				// Swap back
				tmp = x2;
				x2 = x3;
				x3 = tmp;
				tmp = z2;
				z2 = z3;
				z3 = tmp;
			end
		end
		rx = 16'(x2);
		rz = 16'(z2);
	endtask

	// Entered on a rising edge with the DUT idle
	task automatic start_run(input logic [15:0] k, input logic [15:0] u);
		logic [15:0] ex;
		logic [15:0] ez;
		ladder_model(k, u, ex, ez);
		exp_x_q.push_back(ex);
		exp_z_q.push_back(ez);
		accepted++;
		first_start = 1'b1;
		start  <= 1'b1;
		scalar <= k;
		base_u <= u;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Returns on the edge that ends the done cycle
	task automatic wait_done();
		do @(negedge clk); while (!done);
		@(posedge clk);
	endtask

	task automatic run_and_check(input logic [15:0] k, input logic [15:0] u);
		start_run(k, u);
		wait_done();
		repeat (5) @(posedge clk);
	endtask

	task automatic start_while_busy(input logic [15:0] k, input logic [15:0] u,
		input logic [15:0] k_other, input logic [15:0] u_other);
		start_run(k, u);
		repeat (300) @(posedge clk);	// Inside the first steps
		assert (busy)
			else begin
				$display("second start issued while the DUT was idle at %0t", $time);
				proto_errors++;
			end
		start  <= 1'b1;					// Must be dropped
		scalar <= k_other;
		base_u <= u_other;
		@(posedge clk);
		start <= 1'b0;
		wait_done();
		repeat (8) @(posedge clk);
	endtask

	initial begin
		seed = 2;
		reset  <= 1'b1;
		start  <= 1'b0;
		base_u <= 16'd0;
		scalar <= 16'd0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);		// Idle while the monitor watches busy and done

		run_and_check(16'h0000, 16'd9);		// Zero scalar keeps (1,0)
		run_and_check(16'h0000, 16'd40000);
		run_and_check(16'h0001, 16'd9);
		run_and_check(16'h0002, 16'd9);
		run_and_check(16'hffff, 16'd12345);

		for (int i = 0; i < 8; i++) begin
			rand_k = 16'($random(seed));
			rand_u = 16'($unsigned($random(seed)) % 32'd65521);
			run_and_check(rand_k, rand_u);
		end

		start_while_busy(16'h5a3c, 16'd777, 16'h1234, 16'd4242);

		// Back to back runs with each start the cycle after done
		start_run(16'hbeef, 16'd9);
		wait_done();
		start_run(16'h0000, 16'd1234);
		wait_done();
		start_run(16'h0003, 16'd9);
		wait_done();
		repeat (20) @(posedge clk);

		assert (done_count == accepted)
			else begin
				$display("%0d accepted starts gave %0d done pulses", accepted, done_count);
				proto_errors++;
			end
		$display("Checks: %0d, value errors: %0d, protocol errors: %0d",
			checks, value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0 && checks > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
